// File: verilog/monitor_params.svh
`ifndef MONITOR_PARAMS_SVH
`define MONITOR_PARAMS_SVH

// widths
`define BYTECNT_SIZE 7              // byte count field of the register bus
`define DRP_ADDR_W 7                // drp word address
`define DRP_DATA_W 16               // drp data word
`define ALARM_W 5                   // number of alarm levels

// register bus addresses
`define REG_ADDR_DRP_ADDR 8'h29     // drp address and command
`define REG_ADDR_DRP_DATA 8'h2a     // drp write data / read data
`define REG_ADDR_STAT 8'h2b         // sticky alarm status

// drp register map, measurement words
`define DRP_ADDR_TEMP 7'h00         // die temperature
`define DRP_ADDR_VCCINT 7'h01       // core supply
`define DRP_ADDR_VCCAUX 7'h02       // aux supply
`define DRP_ADDR_VBRAM 7'h06        // block ram supply

// drp register map, upper limit words
`define DRP_ADDR_TEMP_LIMIT 7'h50   // user temperature alarm
`define DRP_ADDR_VCCINT_LIMIT 7'h51
`define DRP_ADDR_VCCAUX_LIMIT 7'h52
`define DRP_ADDR_OT_LIMIT 7'h53     // over-temperature
`define DRP_ADDR_VBRAM_LIMIT 7'h58

// reset values
`define MEAS_RESET 16'h4000         // nominal reading, well under limit
`define LIMIT_RESET 16'hB000        // default upper limit

`endif

// File: verilog/reg_bus_pkg.sv
`include "monitor_params.svh"

package reg_bus_pkg;

  // one request on the byte-wide register bus
  typedef struct packed {
    logic [7:0]               address;  // register select
    logic [`BYTECNT_SIZE-1:0] bytecnt;  // byte index within the register
    logic [7:0]               datai;    // write data
    logic                     read;     // single-cycle read strobe
    logic                     write;    // single-cycle write strobe
  } reg_bus_t;

endpackage

// File: verilog/drp_pkg.sv
`include "monitor_params.svh"

package drp_pkg;

  // command from the front end to the monitor
  typedef struct packed {
    logic [`DRP_ADDR_W-1:0] addr;  // word address
    logic                   den;   // one-cycle enable
    logic                   dwe;   // qualifies den as a write
    logic [`DRP_DATA_W-1:0] din;   // write data
  } drp_req_t;

  // answer from the monitor
  typedef struct packed {
    logic [`DRP_DATA_W-1:0] dout;  // read data, held until next read
    logic                   drdy;  // one cycle after den
  } drp_rsp_t;

  // alarm levels, declared msb first so ot lands on bit 0
  // matches the status register layout
  typedef struct packed {
    logic vbram;      // bit 4
    logic vccaux;     // bit 3
    logic vccint;     // bit 2
    logic user_temp;  // bit 1
    logic ot;         // bit 0
  } alarm_t;

endpackage

// File: verilog/xadc_reg.sv
`timescale 1ns/1ps
`include "monitor_params.svh"

module xadc_reg
  import reg_bus_pkg::*, drp_pkg::*;
(
  input  logic     clk_usb,
  input  logic     reset_i,
  input  reg_bus_t bus,        // register bus request
  output drp_req_t drp_req,    // command to the monitor
  input  drp_rsp_t drp_rsp,    // read data from the monitor
  input  alarm_t   alarm,      // live alarm levels
  output logic [7:0] reg_datao,  // registered read data
  output logic     xadc_error  // any live alarm
);

  // drp access sequence, as seen from the bus
  // write: load both data lanes, then write the address with bit 7 set
  // read: write the address with bit 7 clear, then read the data lanes

  logic [`DRP_ADDR_W-1:0] drp_addr;   // last address issued
  logic [`DRP_DATA_W-1:0] drp_din;    // write data, built a byte at a time
  logic                   drp_den;
  logic                   drp_dwe;

  logic [`ALARM_W-1:0] live_stat;     // alarm levels as a vector
  logic [`ALARM_W-1:0] stat_hold;     // sticky copy

  logic lane;                         // byte lane from bytecnt
  logic wr_drp_addr;
  logic wr_drp_data;
  logic wr_stat;

  assign lane = bus.bytecnt[0];       // 16-bit registers, two lanes
  assign wr_drp_addr = bus.write && (bus.address == `REG_ADDR_DRP_ADDR);
  assign wr_drp_data = bus.write && (bus.address == `REG_ADDR_DRP_DATA);
  assign wr_stat = bus.write && (bus.address == `REG_ADDR_STAT);

  assign live_stat = alarm;           // ot at bit 0
  assign xadc_error = |live_stat;     // combinational, same cycle as level

  assign drp_req = '{addr: drp_addr, den: drp_den, dwe: drp_dwe, din: drp_din};

  // command pulses, one cycle after the address write
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      drp_den <= 1'b0;
      drp_dwe <= 1'b0;
    end else begin
      drp_den <= wr_drp_addr;                    // single-cycle pulse
      drp_dwe <= wr_drp_addr && bus.datai[7];    // msb picks write
    end
  end

  // address and write data hold their value
  always_ff @(posedge clk_usb) begin
    if (wr_drp_addr) begin
      drp_addr <= bus.datai[6:0];                // new command replaces old
    end
    if (wr_drp_data) begin
      if (lane) begin
        drp_din[15:8] <= bus.datai;              // upper lane
      end else begin
        drp_din[7:0] <= bus.datai;               // lower lane
      end
    end
  end

  // levels may only last a few cycles, keep them until cleared
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      stat_hold <= '0;
    end else if (wr_stat) begin
      stat_hold <= '0;                           // any write clears all bits
    end else begin
      stat_hold <= stat_hold | live_stat;
    end
  end

  // read mux, data out the cycle after the strobe
  always_ff @(posedge clk_usb) begin
    if (bus.read) begin
      case (bus.address)
        `REG_ADDR_DRP_ADDR: reg_datao <= {1'b0, drp_addr};
        `REG_ADDR_DRP_DATA: begin
          if (lane) begin
            reg_datao <= drp_rsp.dout[15:8];
          end else begin
            reg_datao <= drp_rsp.dout[7:0];
          end
        end
        `REG_ADDR_STAT: reg_datao <= {3'b000, stat_hold};
        default: reg_datao <= 8'h00;             // unmapped reads as zero
      endcase
    end else begin
      reg_datao <= 8'h00;                        // idle bus reads zero
    end
  end

endmodule

// File: verilog/sysmon_model.sv
`timescale 1ns/1ps
`include "monitor_params.svh"

module sysmon_model
  import drp_pkg::*;
(
  input  logic     clk_usb,
  input  logic     reset_i,
  input  drp_req_t drp_req,   // command from the front end
  output drp_rsp_t drp_rsp,   // read data and ready
  output alarm_t   alarm      // registered alarm levels
);

  localparam int NUM_WORDS = 1 << `DRP_ADDR_W;  // 128 words

  logic [`DRP_DATA_W-1:0] mem [0:NUM_WORDS-1];  // drp register file
  logic [`DRP_DATA_W-1:0] dout_q;               // last read word
  logic                   drdy_q;
  logic                   wr_en;
  logic                   rd_en;
  alarm_t                 alarm_nx;

  assign wr_en = drp_req.den && drp_req.dwe;
  assign rd_en = drp_req.den && !drp_req.dwe;

  assign drp_rsp = '{dout: dout_q, drdy: drdy_q};

  // power-on contents of each word
  function automatic logic [`DRP_DATA_W-1:0] reset_word(input logic [`DRP_ADDR_W-1:0] a);
    case (a)
      `DRP_ADDR_TEMP, `DRP_ADDR_VCCINT,
      `DRP_ADDR_VCCAUX, `DRP_ADDR_VBRAM: reset_word = `MEAS_RESET;
      `DRP_ADDR_OT_LIMIT, `DRP_ADDR_TEMP_LIMIT, `DRP_ADDR_VCCINT_LIMIT,
      `DRP_ADDR_VCCAUX_LIMIT, `DRP_ADDR_VBRAM_LIMIT: reset_word = `LIMIT_RESET;
      default: reset_word = '0;
    endcase
  endfunction

  // word value after this edge, write data forwarded
  function automatic logic [`DRP_DATA_W-1:0] next_word(input logic [`DRP_ADDR_W-1:0] a);
    if (wr_en && (drp_req.addr == a)) begin
      next_word = drp_req.din;
    end else begin
      next_word = mem[a];
    end
  endfunction

  // upper limit compares, strictly greater than
  // compare uses the forwarded word so a level rises one cycle after den
  always_comb begin
    alarm_nx.ot        = next_word(`DRP_ADDR_TEMP) > next_word(`DRP_ADDR_OT_LIMIT);
    alarm_nx.user_temp = next_word(`DRP_ADDR_TEMP) > next_word(`DRP_ADDR_TEMP_LIMIT);
    alarm_nx.vccint    = next_word(`DRP_ADDR_VCCINT) > next_word(`DRP_ADDR_VCCINT_LIMIT);
    alarm_nx.vccaux    = next_word(`DRP_ADDR_VCCAUX) > next_word(`DRP_ADDR_VCCAUX_LIMIT);
    alarm_nx.vbram     = next_word(`DRP_ADDR_VBRAM) > next_word(`DRP_ADDR_VBRAM_LIMIT);
  end

  // register file, loaded with defaults on reset
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      for (int i = 0; i < NUM_WORDS; i++) begin
        mem[i] <= reset_word(`DRP_ADDR_W'(i));
      end
    end else begin
      if (wr_en) begin
        mem[drp_req.addr] <= drp_req.din;   // measurements writable too
      end
      if (rd_en) begin
        dout_q <= mem[drp_req.addr];        // holds until next read
      end
    end
  end

  // ready pulse and alarm levels
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      drdy_q <= 1'b0;
      alarm  <= '0;
    end else begin
      drdy_q <= drp_req.den;                // every den answered next cycle
      alarm  <= alarm_nx;
    end
  end

endmodule

// File: verilog/monitor_top.sv
`timescale 1ns/1ps

module monitor_top
  import reg_bus_pkg::*, drp_pkg::*;
(
  input  logic       clk_usb,
  input  logic       reset_i,
  input  reg_bus_t   bus,         // register bus from the host side
  output logic [7:0] reg_datao,   // read data, one cycle after read
  output logic       xadc_error   // any live alarm
);

  drp_req_t drp_req;   // front end to monitor
  drp_rsp_t drp_rsp;   // monitor to front end
  alarm_t   alarm;     // live alarm levels

  // register front end
  xadc_reg u_xadc_reg (
    .clk_usb    (clk_usb),
    .reset_i    (reset_i),
    .bus        (bus),
    .drp_req    (drp_req),
    .drp_rsp    (drp_rsp),
    .alarm      (alarm),
    .reg_datao  (reg_datao),
    .xadc_error (xadc_error)
  );

  // behavioural stand-in for the system monitor
  sysmon_model u_sysmon_model (
    .clk_usb (clk_usb),
    .reset_i (reset_i),
    .drp_req (drp_req),
    .drp_rsp (drp_rsp),
    .alarm   (alarm)
  );

endmodule

// File: tb/monitor_tb.sv
`timescale 1ns/1ps
`include "monitor_params.svh"

module monitor_tb
  import reg_bus_pkg::*;
;

  localparam int MAX_CYCLES = 3000;  // tests take about 350 cycles, wide margin

  logic       clk_usb;
  logic       reset_i;
  reg_bus_t   bus;
  logic [7:0] reg_datao;
  logic       xadc_error;

  string       cur_test;
  int          errs;
  int          test_errs;
  int          checks;
  int          tests;
  int          cycles;
  logic [7:0]  rd;
  logic [31:0] rnd;
  logic [15:0] val;
  logic [6:0]  addr;
  logic        seen;

  monitor_top dut (
    .clk_usb    (clk_usb),
    .reset_i    (reset_i),
    .bus        (bus),
    .reg_datao  (reg_datao),
    .xadc_error (xadc_error)
  );

  always #10 clk_usb = ~clk_usb;  // 20 ns period

  // one write strobe, bus idle again afterwards
  task automatic bus_write(input logic [7:0] a, input logic [`BYTECNT_SIZE-1:0] cnt,
                           input logic [7:0] data);
    @(posedge clk_usb);
    bus <= '{address: a, bytecnt: cnt, datai: data, read: 1'b0, write: 1'b1};
    @(posedge clk_usb);
    bus <= '0;
  endtask

  // read strobe, data sampled mid-cycle after the strobe
  task automatic bus_read(input logic [7:0] a, input logic [`BYTECNT_SIZE-1:0] cnt,
                          output logic [7:0] data);
    @(posedge clk_usb);
    bus <= '{address: a, bytecnt: cnt, datai: 8'h00, read: 1'b1, write: 1'b0};
    @(posedge clk_usb);
    bus <= '0;
    @(negedge clk_usb);
    data = reg_datao;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk_usb);
  endtask

  // both lanes, then the address with the write bit
  task automatic drp_write_word(input logic [6:0] a, input logic [15:0] data);
    bus_write(`REG_ADDR_DRP_DATA, 0, data[7:0]);
    bus_write(`REG_ADDR_DRP_DATA, 1, data[15:8]);
    bus_write(`REG_ADDR_DRP_ADDR, 0, {1'b1, a});
  endtask

  task automatic check_value(input string what, input logic [15:0] expected,
                             input logic [15:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, expected, actual);
      errs++;
      test_errs++;
    end
  endtask

  // output must drop to zero after an idle bus cycle
  task automatic check_idle_zero();
    @(negedge clk_usb);
    check_value("idle reg_datao", 16'h0000, 16'(reg_datao));
  endtask

  // bounded wait for the error level
  task automatic wait_error_level(input logic level, input int max_cycles);
    int i;
    seen = 1'b0;
    for (i = 0; i < max_cycles && !seen; i++) begin
      @(negedge clk_usb);
      if (xadc_error === level) seen = 1'b1;
    end
    checks++;
    assert (seen) else begin
      $display("test %s: xadc_error did not reach %b within %0d cycles",
               cur_test, level, max_cycles);
      errs++;
      test_errs++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_errs = 0;
    tests++;
  endtask

  task automatic end_test();
    if (test_errs == 0) $display("test %s: passed", cur_test);
    else $display("test %s: failed with %0d errors", cur_test, test_errs);
  endtask

  // hang guard
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk_usb);
      cycles++;
    end
    $display("timeout: run still going after %0d cycles", MAX_CYCLES);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    clk_usb = 1'b0;
    reset_i = 1'b1;
    bus = '0;
    errs = 0;
    checks = 0;
    tests = 0;
    rnd = $urandom(32'he9dc);  // seed once
    repeat (4) @(posedge clk_usb);
    reset_i <= 1'b0;
    idle_cycles(2);

    start_test("reset_state");
    bus_read(`REG_ADDR_STAT, 0, rd);
    check_value("status", 16'h0000, 16'(rd));
    check_value("xadc_error", 16'h0000, 16'(xadc_error));
    bus_read(8'h00, 0, rd);  // unmapped
    check_value("unmapped", 16'h0000, 16'(rd));
    check_idle_zero();
    end_test();

    start_test("drp_round_trip");
    repeat (5) begin
      rnd = $urandom;
      val = rnd[15:0];
      drp_write_word(7'h40, val);
      idle_cycles(4);  // access spacing
      bus_write(`REG_ADDR_DRP_ADDR, 0, 8'h40);  // read, bit 7 clear
      idle_cycles(4);
      bus_read(`REG_ADDR_DRP_DATA, 0, rd);
      check_value("low byte", 16'(val[7:0]), 16'(rd));
      check_idle_zero();
      bus_read(`REG_ADDR_DRP_DATA, 1, rd);
      check_value("high byte", 16'(val[15:8]), 16'(rd));
      check_idle_zero();
    end
    end_test();

    start_test("drp_addr_readback");
    repeat (4) begin
      rnd = $urandom;
      addr = 7'h40 | {3'b000, rnd[3:0]};  // unmapped words only
      bus_write(`REG_ADDR_DRP_ADDR, 0, {rnd[4], addr});  // random read or write
      idle_cycles(4);
      bus_read(`REG_ADDR_DRP_ADDR, 0, rd);
      check_value("drp addr", 16'({1'b0, addr}), 16'(rd));
    end
    end_test();

    start_test("live_alarm");
    drp_write_word(`DRP_ADDR_VCCINT, 16'hC000);  // above limit
    wait_error_level(1'b1, 4);
    idle_cycles(2);
    bus_read(`REG_ADDR_STAT, 0, rd);
    check_value("status", 16'h0004, 16'(rd));  // vccint bit only
    idle_cycles(4);
    drp_write_word(`DRP_ADDR_VCCINT, 16'hB000);  // equal to limit, no alarm
    wait_error_level(1'b0, 4);
    idle_cycles(2);
    bus_read(`REG_ADDR_STAT, 0, rd);
    check_value("sticky status", 16'h0004, 16'(rd));
    end_test();

    start_test("clear_and_temp");
    bus_write(`REG_ADDR_STAT, 0, 8'h00);
    bus_read(`REG_ADDR_STAT, 0, rd);
    check_value("cleared status", 16'h0000, 16'(rd));
    idle_cycles(4);
    drp_write_word(`DRP_ADDR_TEMP, 16'hC000);  // trips ot and user temp
    wait_error_level(1'b1, 4);
    idle_cycles(2);
    bus_read(`REG_ADDR_STAT, 0, rd);
    check_value("temp status", 16'h0003, 16'(rd));
    end_test();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errs);
    if (errs == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+verilog
verilog/reg_bus_pkg.sv
verilog/drp_pkg.sv
verilog/xadc_reg.sv
verilog/sysmon_model.sv
verilog/monitor_top.sv
tb/monitor_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the monitor testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module monitor_tb \
  -f all.f \
  -o monitor_sim

./obj_dir/monitor_sim | tee sim.log

if grep -q "Finished with errors" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
